// ==== fp_pkg.sv ====
package fp_pkg;

    ////////////////////////////////////////////////////////////
    // IEEE single precision layout
    ////////////////////////////////////////////////////////////

    // Full word width
    localparam int WORD_W = 32;

    // Biased exponent field
    localparam int EXP_W = 8;

    // Stored fraction, hidden bit not included
    localparam int SIG_W = 23;

    // Exponent bias for single precision
    localparam int EXP_BIAS = 127;

    // All-ones exponent marks infinity
    localparam int EXP_MAX = 255;

    ////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////

    // Packed word as {sign, exponent, fraction}
    typedef logic [WORD_W-1:0] fp_word_t;

    typedef logic [EXP_W-1:0] exp_t;

    typedef logic [SIG_W-1:0] sig_t;

    // Which operator produced a result
    typedef enum logic {
        SRC_ADD = 1'b0,
        SRC_MUL = 1'b1
    } src_t;

endpackage

// ==== fp_format_stage.sv ====
`timescale 1ns/1ps

module fp_format_stage (
    input  logic             overflow_flag,
    input  logic             underflow_flag,
    input  logic             sign,
    input  fp_pkg::exp_t     exp,
    input  fp_pkg::sig_t     sig,
    output fp_pkg::fp_word_t formatted_number
);

    // Selected exponent and fraction
    fp_pkg::exp_t exp_sel;
    fp_pkg::sig_t sig_sel;

    // Overflow checked first
    always_comb begin
        if (overflow_flag) begin
            // Infinity keeps the computed sign
            exp_sel = fp_pkg::exp_t'(fp_pkg::EXP_MAX);
            sig_sel = '0;
        end else if (underflow_flag) begin
            // Signed zero
            exp_sel = '0;
            sig_sel = '0;
        end else begin
            exp_sel = exp;
            sig_sel = sig;
        end
    end

    // Sign always passes through
    assign formatted_number = {sign, exp_sel, sig_sel};

endmodule

// ==== fp_add_sub.sv ====
`timescale 1ns/1ps

module fp_add_sub (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    input  logic             sub,
    output logic             busy,
    output logic             req,
    input  logic             gnt,
    output logic             sign,
    output fp_pkg::exp_t     exp,
    output fp_pkg::sig_t     sig,
    output logic             ovf,
    output logic             unf
);

    // Operand fields after zero flush
    fp_pkg::exp_t            exp_a;
    fp_pkg::exp_t            exp_b;
    logic [fp_pkg::SIG_W:0]  man_a;
    logic [fp_pkg::SIG_W:0]  man_b;
    logic                    sign_b_eff;
    logic                    a_big;

    // Ordered operands
    fp_pkg::exp_t            big_exp;
    fp_pkg::exp_t            exp_diff;
    fp_pkg::exp_t            shamt;
    logic [fp_pkg::SIG_W:0]  big_man;
    logic [fp_pkg::SIG_W:0]  small_man;
    logic [2*fp_pkg::SIG_W+7:0] align_wide;
    logic [fp_pkg::SIG_W+3:0]   small_al;

    // Stage 1 registers
    logic                     s1_valid;
    logic                     s1_sign;
    logic                     s1_eff_sub;
    fp_pkg::exp_t             s1_exp;
    logic [fp_pkg::SIG_W+3:0] s1_big;
    logic [fp_pkg::SIG_W+3:0] s1_small;

    // Stage 2 datapath
    logic [fp_pkg::SIG_W+4:0]        sum;
    logic [fp_pkg::SIG_W+4:0]        norm;
    logic [4:0]                      lz;
    logic signed [fp_pkg::EXP_W+1:0] exp_calc;
    logic                            sum_zero;

    // Leading zeros of the raw sum
    function automatic logic [4:0] count_lz(input logic [fp_pkg::SIG_W+4:0] v);
        logic [4:0] n;
        logic       hit;
        n = '0;
        hit = 1'b0;
        for (int i = fp_pkg::SIG_W + 4; i >= 0; i--) begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 5'd1;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stage 1 unpack, swap, align
    ////////////////////////////////////////////////////////////

    assign exp_a = a[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign exp_b = b[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];

    // Exponent 0 flushes to zero, hidden bit otherwise
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a[fp_pkg::SIG_W-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b[fp_pkg::SIG_W-1:0]};

    // Subtraction flips the sign of b
    assign sign_b_eff = b[fp_pkg::WORD_W-1] ^ sub;

    // Magnitude compare on exponent then significand
    assign a_big = {exp_a, man_a} >= {exp_b, man_b};

    assign big_exp   = a_big ? exp_a : exp_b;
    assign big_man   = a_big ? man_a : man_b;
    assign small_man = a_big ? man_b : man_a;
    assign exp_diff  = a_big ? (exp_a - exp_b) : (exp_b - exp_a);

    // Shifts past the extended width all land in sticky
    assign shamt = (exp_diff > fp_pkg::exp_t'(fp_pkg::SIG_W + 4)) ?
                   fp_pkg::exp_t'(fp_pkg::SIG_W + 4) : exp_diff;

    // Three extra bits below the lsb, then a catch area for sticky
    assign align_wide = {small_man, 3'b000, {(fp_pkg::SIG_W + 4){1'b0}}} >> shamt;

    assign small_al = {align_wide[2*fp_pkg::SIG_W+7:fp_pkg::SIG_W+5],
                       align_wide[fp_pkg::SIG_W+4] | (|align_wide[fp_pkg::SIG_W+3:0])};

    always_ff @(posedge clk) begin
        if (start) begin
            s1_sign    <= a_big ? a[fp_pkg::WORD_W-1] : sign_b_eff;
            s1_eff_sub <= a[fp_pkg::WORD_W-1] ^ sign_b_eff;
            s1_exp     <= big_exp;
            s1_big     <= {big_man, 3'b000};
            s1_small   <= small_al;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 add, normalize, flags
    ////////////////////////////////////////////////////////////

    // big >= small so the difference never goes negative
    assign sum = s1_eff_sub ? ({1'b0, s1_big} - {1'b0, s1_small}) :
                              ({1'b0, s1_big} + {1'b0, s1_small});

    assign sum_zero = (sum == '0);
    assign lz       = count_lz(sum);
    assign norm     = sum << lz;

    // Carry out gives lz of 0 and bumps the exponent
    assign exp_calc = $signed({2'b00, s1_exp}) + $signed(10'sd1) - $signed({5'b00000, lz});

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            if (sum_zero) begin
                // Cancellation lands on +0, zero plus zero keeps its sign
                sign <= s1_eff_sub ? 1'b0 : s1_sign;
                exp  <= '0;
                sig  <= '0;
                ovf  <= 1'b0;
                unf  <= 1'b0;
            end else begin
                sign <= s1_sign;
                exp  <= exp_calc[fp_pkg::EXP_W-1:0];
                // Truncate below the fraction
                sig  <= norm[fp_pkg::SIG_W+3:4];
                ovf  <= exp_calc >= fp_pkg::EXP_MAX;
                unf  <= exp_calc <= 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshake control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            busy     <= 1'b0;
            req      <= 1'b0;
        end else begin
            s1_valid <= start;
            if (start)
                busy <= 1'b1;
            else if (gnt)
                busy <= 1'b0;
            // Request held until the arbiter answers
            if (s1_valid)
                req <= 1'b1;
            else if (gnt)
                req <= 1'b0;
        end
    end

    // No new operation while one is in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

    // Request holds until granted
    a_req_hold: assert property (@(posedge clk) disable iff (rst) req && !gnt |=> req);

endmodule

// ==== fp_mul.sv ====
`timescale 1ns/1ps

module fp_mul (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    output logic             busy,
    output logic             req,
    input  logic             gnt,
    output logic             sign,
    output fp_pkg::exp_t     exp,
    output fp_pkg::sig_t     sig,
    output logic             ovf,
    output logic             unf
);

    // Unpacked operands
    fp_pkg::exp_t                    exp_a;
    fp_pkg::exp_t                    exp_b;
    logic [fp_pkg::SIG_W:0]          man_a;
    logic [fp_pkg::SIG_W:0]          man_b;
    logic signed [fp_pkg::EXP_W+1:0] exp_sum;

    // Stage 1 registers
    logic                            s1_valid;
    logic                            s1_sign;
    logic                            s1_zero;
    logic signed [fp_pkg::EXP_W+1:0] s1_exp;
    logic [2*fp_pkg::SIG_W+1:0]      s1_prod;

    // Stage 2 normalize
    logic                            prod_hi;
    logic signed [fp_pkg::EXP_W+1:0] exp_norm;
    fp_pkg::sig_t                    sig_norm;

    ////////////////////////////////////////////////////////////
    // Stage 1 exponent sum and significand product
    ////////////////////////////////////////////////////////////

    assign exp_a = a[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign exp_b = b[fp_pkg::WORD_W-2 -: fp_pkg::EXP_W];
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a[fp_pkg::SIG_W-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b[fp_pkg::SIG_W-1:0]};

    // Extended width holds both the negative and the over-range sum
    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) -
                     $signed((fp_pkg::EXP_W + 2)'(fp_pkg::EXP_BIAS));

    always_ff @(posedge clk) begin
        if (start) begin
            s1_sign <= a[fp_pkg::WORD_W-1] ^ b[fp_pkg::WORD_W-1];
            s1_zero <= (exp_a == '0) || (exp_b == '0);
            s1_exp  <= exp_sum;
            s1_prod <= man_a * man_b;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 one-position normalize and flags
    ////////////////////////////////////////////////////////////

    // Product of two 1.x values lies in [1, 4)
    assign prod_hi  = s1_prod[2*fp_pkg::SIG_W+1];
    assign exp_norm = s1_exp + $signed({{(fp_pkg::EXP_W + 1){1'b0}}, prod_hi});
    assign sig_norm = prod_hi ? s1_prod[2*fp_pkg::SIG_W:fp_pkg::SIG_W+1] :
                                s1_prod[2*fp_pkg::SIG_W-1:fp_pkg::SIG_W];

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            sign <= s1_sign;
            exp  <= exp_norm[fp_pkg::EXP_W-1:0];
            sig  <= sig_norm;
            // zero operand rides the underflow path
            ovf  <= !s1_zero && (exp_norm >= fp_pkg::EXP_MAX);
            unf  <= s1_zero || (exp_norm <= 0);
        end
    end

    // Busy and request follow the adder handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            busy     <= 1'b0;
            req      <= 1'b0;
        end else begin
            s1_valid <= start;
            if (start)
                busy <= 1'b1;
            else if (gnt)
                busy <= 1'b0;
            if (s1_valid)
                req <= 1'b1;
            else if (gnt)
                req <= 1'b0;
        end
    end

    // Single operation in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== fp_result_arbiter.sv ====
`timescale 1ns/1ps

module fp_result_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             add_req,
    output logic             add_gnt,
    input  logic             add_sign,
    input  fp_pkg::exp_t     add_exp,
    input  fp_pkg::sig_t     add_sig,
    input  logic             add_ovf,
    input  logic             add_unf,
    input  logic             mul_req,
    output logic             mul_gnt,
    input  logic             mul_sign,
    input  fp_pkg::exp_t     mul_exp,
    input  fp_pkg::sig_t     mul_sig,
    input  logic             mul_ovf,
    input  logic             mul_unf,
    output fp_pkg::fp_word_t result,
    output fp_pkg::src_t     result_src,
    output logic             result_valid
);

    // Peer favored on a tie
    fp_pkg::src_t     prio;
    fp_pkg::src_t     sel;

    // Granted fields into the packer
    logic             f_sign;
    fp_pkg::exp_t     f_exp;
    fp_pkg::sig_t     f_sig;
    logic             f_ovf;
    logic             f_unf;
    fp_pkg::fp_word_t packed_word;

    ////////////////////////////////////////////////////////////
    // Round-robin grant
    ////////////////////////////////////////////////////////////

    assign add_gnt = add_req && (!mul_req || prio == fp_pkg::SRC_ADD);
    assign mul_gnt = mul_req && (!add_req || prio == fp_pkg::SRC_MUL);

    assign sel = mul_gnt ? fp_pkg::SRC_MUL : fp_pkg::SRC_ADD;

    // Field mux
    assign f_sign = mul_gnt ? mul_sign : add_sign;
    assign f_exp  = mul_gnt ? mul_exp  : add_exp;
    assign f_sig  = mul_gnt ? mul_sig  : add_sig;
    assign f_ovf  = mul_gnt ? mul_ovf  : add_ovf;
    assign f_unf  = mul_gnt ? mul_unf  : add_unf;

    fp_format_stage u_fmt (
        .overflow_flag    (f_ovf),
        .underflow_flag   (f_unf),
        .sign             (f_sign),
        .exp              (f_exp),
        .sig              (f_sig),
        .formatted_number (packed_word)
    );

    // Pointer moves to the peer not served
    always_ff @(posedge clk) begin
        if (rst) begin
            prio         <= fp_pkg::SRC_ADD;
            result_valid <= 1'b0;
        end else begin
            result_valid <= add_gnt || mul_gnt;
            if (add_gnt)
                prio <= fp_pkg::SRC_MUL;
            else if (mul_gnt)
                prio <= fp_pkg::SRC_ADD;
        end
    end

    // Output word and source
    always_ff @(posedge clk) begin
        if (add_gnt || mul_gnt) begin
            result     <= packed_word;
            result_src <= sel;
        end
    end

    // One grant per cycle
    a_one_gnt: assert property (@(posedge clk) disable iff (rst) !(add_gnt && mul_gnt));

    // A held request that lost is served next cycle
    a_add_next: assert property (@(posedge clk) disable iff (rst)
        add_req && !add_gnt |=> add_gnt);
    a_mul_next: assert property (@(posedge clk) disable iff (rst)
        mul_req && !mul_gnt |=> mul_gnt);

endmodule

// ==== fp_unit_top.sv ====
`timescale 1ns/1ps

module fp_unit_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             add_start,
    input  fp_pkg::fp_word_t add_a,
    input  fp_pkg::fp_word_t add_b,
    input  logic             add_sub,
    output logic             add_busy,
    input  logic             mul_start,
    input  fp_pkg::fp_word_t mul_a,
    input  fp_pkg::fp_word_t mul_b,
    output logic             mul_busy,
    output fp_pkg::fp_word_t result,
    output fp_pkg::src_t     result_src,
    output logic             result_valid
);

    // Adder to arbiter
    logic         add_req;
    logic         add_gnt;
    logic         add_sign;
    fp_pkg::exp_t add_exp;
    fp_pkg::sig_t add_sig;
    logic         add_ovf;
    logic         add_unf;

    // Multiplier to arbiter
    logic         mul_req;
    logic         mul_gnt;
    logic         mul_sign;
    fp_pkg::exp_t mul_exp;
    fp_pkg::sig_t mul_sig;
    logic         mul_ovf;
    logic         mul_unf;

    fp_add_sub u_add (
        .clk   (clk),
        .rst   (rst),
        .start (add_start),
        .a     (add_a),
        .b     (add_b),
        .sub   (add_sub),
        .busy  (add_busy),
        .req   (add_req),
        .gnt   (add_gnt),
        .sign  (add_sign),
        .exp   (add_exp),
        .sig   (add_sig),
        .ovf   (add_ovf),
        .unf   (add_unf)
    );

    fp_mul u_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .busy  (mul_busy),
        .req   (mul_req),
        .gnt   (mul_gnt),
        .sign  (mul_sign),
        .exp   (mul_exp),
        .sig   (mul_sig),
        .ovf   (mul_ovf),
        .unf   (mul_unf)
    );

    // Shared packing path
    fp_result_arbiter u_arb (
        .clk          (clk),
        .rst          (rst),
        .add_req      (add_req),
        .add_gnt      (add_gnt),
        .add_sign     (add_sign),
        .add_exp      (add_exp),
        .add_sig      (add_sig),
        .add_ovf      (add_ovf),
        .add_unf      (add_unf),
        .mul_req      (mul_req),
        .mul_gnt      (mul_gnt),
        .mul_sign     (mul_sign),
        .mul_exp      (mul_exp),
        .mul_sig      (mul_sig),
        .mul_ovf      (mul_ovf),
        .mul_unf      (mul_unf),
        .result       (result),
        .result_src   (result_src),
        .result_valid (result_valid)
    );

endmodule

// ==== tb_fp_unit.sv ====
`timescale 1ns/1ps

module tb_fp_unit;

    // Room for vectors in the golden file
    localparam int MAX_VEC  = 64;
    localparam int CLK_HALF = 10;

    // Op codes in the first column
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_MUL = 2;

    // DUT ports
    logic             clk;
    logic             rst;
    logic             add_start;
    fp_pkg::fp_word_t add_a;
    fp_pkg::fp_word_t add_b;
    logic             add_sub;
    logic             add_busy;
    logic             mul_start;
    fp_pkg::fp_word_t mul_a;
    fp_pkg::fp_word_t mul_b;
    logic             mul_busy;
    fp_pkg::fp_word_t result;
    fp_pkg::src_t     result_src;
    logic             result_valid;

    // Four words per vector holding op, a, b and expected
    logic [31:0] golden [0:4*MAX_VEC-1];
    int          num_vec;
    bit          loaded;

    // Vector indices in flight, one queue per source
    int add_q[$];
    int mul_q[$];

    int          errors;
    int          passed;
    int          done_cnt;
    logic [31:0] lcg_state;

    fp_unit_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .add_start    (add_start),
        .add_a        (add_a),
        .add_b        (add_b),
        .add_sub      (add_sub),
        .add_busy     (add_busy),
        .mul_start    (mul_start),
        .mul_a        (mul_a),
        .mul_b        (mul_b),
        .mul_busy     (mul_busy),
        .result       (result),
        .result_src   (result_src),
        .result_valid (result_valid)
    );

    always #CLK_HALF clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Gap length and pairing choice
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int op_of(input int idx);
        return int'(golden[4*idx]);
    endfunction

    // Multiplier results come back tagged SRC_MUL
    function automatic fp_pkg::src_t src_of(input int idx);
        if (op_of(idx) == OP_MUL)
            return fp_pkg::SRC_MUL;
        return fp_pkg::SRC_ADD;
    endfunction

    function automatic string op_name(input int idx);
        case (op_of(idx))
            OP_ADD:  return "add";
            OP_SUB:  return "sub";
            default: return "mul";
        endcase
    endfunction

    task automatic check_word(input string name, input fp_pkg::fp_word_t got,
                              input fp_pkg::fp_word_t want, output bit ok);
        ok = (got === want);
        if (!ok) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_src(input string name, input fp_pkg::src_t got,
                             input fp_pkg::src_t want, output bit ok);
        ok = (got === want);
        if (!ok) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    // Single-bit status outputs
    task automatic check_flag(input string name, input logic got,
                              input logic want, output bit ok);
        ok = (got === want);
        if (!ok) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    // Drive one vector onto its peer and queue it
    task automatic load_vector(input int idx);
        if (op_of(idx) == OP_MUL) begin
            mul_a     = golden[4*idx+1];
            mul_b     = golden[4*idx+2];
            mul_start = 1'b1;
            mul_q.push_back(idx);
        end else begin
            add_a     = golden[4*idx+1];
            add_b     = golden[4*idx+2];
            add_sub   = (op_of(idx) == OP_SUB);
            add_start = 1'b1;
            add_q.push_back(idx);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Result collection
    ////////////////////////////////////////////////////////////

    // Outputs sampled on the falling edge after they settle
    always @(negedge clk) begin : collect
        int idx;
        bit have;
        bit ok_word;
        bit ok_src;
        if (result_valid === 1'b1) begin
            have = 1'b0;
            if (result_src == fp_pkg::SRC_MUL && mul_q.size() > 0) begin
                idx  = mul_q.pop_front();
                have = 1'b1;
            end else if (result_src == fp_pkg::SRC_ADD && add_q.size() > 0) begin
                idx  = add_q.pop_front();
                have = 1'b1;
            end else if (add_q.size() > 0) begin
                // Tag names an idle peer so the result belongs to the other one
                idx  = add_q.pop_front();
                have = 1'b1;
            end else if (mul_q.size() > 0) begin
                idx  = mul_q.pop_front();
                have = 1'b1;
            end
            if (!have) begin
                errors++;
                $display("Result %h from source %0d arrived with nothing pending",
                         result, result_src);
            end else begin
                check_word("result", result, golden[4*idx+3], ok_word);
                check_src("result_src", result_src, src_of(idx), ok_src);
                done_cnt++;
                if (ok_word && ok_src)
                    passed++;
                $display("vector %0d %s %h %h -> %h : %s", idx, op_name(idx),
                         golden[4*idx+1], golden[4*idx+2], result,
                         (ok_word && ok_src) ? "ok" : "FAIL");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : main
        int          idx;
        int          gap;
        bit          pair;
        bit          need_add;
        bit          need_mul;
        bit          ok_v;
        bit          ok_a;
        bit          ok_m;
        logic [31:0] r;
        clk       = 1'b0;
        rst       = 1'b1;
        add_start = 1'b0;
        add_a     = '0;
        add_b     = '0;
        add_sub   = 1'b0;
        mul_start = 1'b0;
        mul_a     = '0;
        mul_b     = '0;
        errors    = 0;
        passed    = 0;
        done_cnt  = 0;
        lcg_state = 32'd95786;
        // Out-of-range op codes past the last vector end the list
        for (int i = 0; i < 4*MAX_VEC; i++)
            golden[i] = 32'hFF00_0000 | i;
        $readmemh("fp_unit_golden.txt", golden);
        num_vec = 0;
        while (num_vec < MAX_VEC && golden[4*num_vec] <= OP_MUL)
            num_vec++;
        loaded = 1'b1;
        if (num_vec == 0) begin
            errors++;
            $display("Golden file fp_unit_golden.txt holds no vectors");
        end

        // Two reset cycles then release on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("result_valid", result_valid, 1'b0, ok_v);
        check_flag("add_busy", add_busy, 1'b0, ok_a);
        check_flag("mul_busy", mul_busy, 1'b0, ok_m);
        $display("reset state : %s", (ok_v && ok_a && ok_m) ? "ok" : "FAIL");

        idx = 0;
        while (idx < num_vec) begin
            r   = lcg_next();
            gap = int'(r[17:16]);
            repeat (gap) @(negedge clk);
            // Adder and multiplier vectors next to each other may go together
            pair = r[20] && (idx + 1 < num_vec) &&
                   ((op_of(idx) == OP_MUL) != (op_of(idx + 1) == OP_MUL));
            need_mul = (op_of(idx) == OP_MUL) || pair;
            need_add = (op_of(idx) != OP_MUL) || pair;
            while ((need_add && add_busy) || (need_mul && mul_busy))
                @(negedge clk);
            load_vector(idx);
            if (pair)
                load_vector(idx + 1);
            @(negedge clk);
            add_start = 1'b0;
            mul_start = 1'b0;
            idx += pair ? 2 : 1;
        end

        // Drain then watch for stray results
        wait (done_cnt == num_vec);
        repeat (10) @(negedge clk);
        if (add_q.size() != 0 || mul_q.size() != 0) begin
            errors++;
            $display("Operations still pending at the end: %0d add, %0d mul",
                     add_q.size(), mul_q.size());
        end

        $display("Summary: %0d vectors, %0d passed, %0d errors", num_vec, passed, errors);
        if (errors == 0 && passed == num_vec)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Run length bound scaled by vector count
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = num_vec * 12 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d clock cycles with results still missing", limit);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== fp_unit_golden.txt ====
// Columns: op a b expected, all hex
// op 0 is add, 1 is sub (a minus b), 2 is mul
// Plain sums and products
0 3F800000 40000000 40400000
2 40000000 40400000 40C00000
0 3FC00000 40200000 40800000
2 3FC00000 3FC00000 40100000
0 40400000 3E800000 40500000
2 C0000000 40200000 C0A00000
1 41200000 3F400000 41140000
2 3F800001 3F800001 3F800002
// Cancellation, truncation and zero operands
1 3F800000 3F800000 00000000
2 3FFFFFFF 3FC00000 403FFFFF
0 BF800000 3F800000 00000000
2 C0400000 00000000 80000000
1 40A00000 40E00000 C0000000
2 00400000 40000000 00000000
0 3F800000 33800000 3F800000
// Overflow to infinity
2 7F000000 40800000 7F800000
0 7F7FFFFF 7F7FFFFF 7F800000
2 FF000000 40000000 FF800000
0 FF7FFFFF FF7FFFFF FF800000
// Underflow to signed zero
2 00800000 BF000000 80000000
1 00800000 00C00000 80000000
2 00800000 3F000000 00000000
1 00C00000 00800000 00000000
0 40000000 00000000 40000000

// ==== verilog.f ====
fp_pkg.sv
fp_format_stage.sv
fp_add_sub.sv
fp_mul.sv
fp_result_arbiter.sv
fp_unit_top.sv
tb_fp_unit.sv

// ==== Makefile ====
# Verilator build and run for the FP unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fp_unit
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
